// ==== src/pat_pkg.sv ====
package pat_pkg;

	// ============================================================
	// core widths
	// ============================================================
	localparam int DATA_W = 8;
	localparam int INSTR_W = 17;
	localparam int REG_AW = 3;

	typedef enum logic [1:0] {
		COND_Z  = 2'd0, // zero flag set
		COND_NZ = 2'd1,
		COND_N  = 2'd2, // negative flag set
		COND_AL = 2'd3
	} cond_e;

	// long form opcodes, 8-bit immediate
	typedef enum logic [3:0] {
		OP8_ORI  = 4'h0,
		OP8_ORR  = 4'h1,
		OP8_ANDI = 4'h2,
		OP8_ANDR = 4'h3,
		OP8_ADDI = 4'h4,
		OP8_ADDR = 4'h5,
		OP8_SUBI = 4'h6,
		OP8_SUBR = 4'h7,
		OP8_LDI  = 4'h8,
		OP8_BF   = 4'hd,
		OP8_PFX  = 4'hf  // escapes to the short form
	} op8_e;

	// short form sub-opcodes, 3-bit immediate
	typedef enum logic [3:0] {
		OP3_SHLZI = 4'h0,
		OP3_SHLZR = 4'h1,
		OP3_SHLOI = 4'h2,
		OP3_SHLOR = 4'h3,
		OP3_SHRZI = 4'h4,
		OP3_SHRZR = 4'h5,
		OP3_SHROI = 4'h6,
		OP3_SHROR = 4'h7,
		OP3_IN    = 4'h8,
		OP3_OUT   = 4'hb,
		OP3_PFX0  = 4'hf  // zero operand op in the low nibble
	} op3_e;

	typedef enum logic [3:0] {
		OP0_NOT  = 4'h0,
		OP0_TEST = 4'h2,
		OP0_NOP  = 4'h5
	} op0_e;

	typedef enum logic [3:0] {
		ALU_OR,
		ALU_AND,
		ALU_ADD,
		ALU_SUB,
		ALU_NOT,
		ALU_SHLZ,
		ALU_SHLO,
		ALU_SHRZ,
		ALU_SHRO,
		ALU_PASS_B
	} alu_op_e;

	// ============================================================
	// instruction word, two readings
	// ============================================================
	typedef struct packed {
		logic [REG_AW-1:0] rn;
		cond_e cond;
		op8_e op8;
		logic [DATA_W-1:0] imm8;
	} instr_long_t;

	typedef struct packed {
		logic [REG_AW-1:0] rn;
		cond_e cond;
		op8_e pfx;
		op3_e op3;
		logic spare; // top bit of the op0 nibble
		logic [2:0] imm3;
	} instr_short_t;

	typedef union packed {
		instr_long_t l;
		instr_short_t s;
	} instr_u;

	localparam instr_u INSTR_NOP = {3'd0, COND_AL, OP8_PFX, OP3_PFX0, OP0_NOP};

endpackage

// ==== src/prog_mem.sv ====
`timescale 1ns/10ps

module prog_mem import pat_pkg::*; #(
	parameter int PROG_AW = 6
) (
	input  logic clk,
	input  logic i_we,
	input  logic [PROG_AW-1:0] i_waddr,
	input  logic [INSTR_W-1:0] i_wdata,
	input  logic [PROG_AW-1:0] i_raddr,
	output logic [INSTR_W-1:0] o_rdata
);

	logic [INSTR_W-1:0] mem [2**PROG_AW];

	always_ff @(posedge clk)
	begin
		if (i_we)
			mem[i_waddr] <= i_wdata; // loader port, only used while idle
		o_rdata <= mem[i_raddr];     // registered read, word out one clock later
	end

endmodule

// ==== src/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit import pat_pkg::*; #(
	parameter int PROG_AW = 6
) (
	input  logic clk,
	input  logic reset,
	input  logic i_run,
	input  logic i_load_en,
	input  logic [PROG_AW-1:0] i_load_addr,
	input  logic [INSTR_W-1:0] i_load_data,
	input  logic i_branch,
	input  logic [PROG_AW-1:0] i_branch_target,
	output logic [PROG_AW-1:0] o_pc,
	output instr_u o_instr,
	output logic [PROG_AW-1:0] o_instr_pc
);

	logic [INSTR_W-1:0] rdata;
	logic valid_q; // word coming out of the memory is live

	prog_mem #(
		.PROG_AW(PROG_AW)
	) prog_mem_i (
		.clk(clk),
		.i_we(i_load_en),
		.i_waddr(i_load_addr),
		.i_wdata(i_load_data),
		.i_raddr(o_pc),
		.o_rdata(rdata)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_pc <= '0;
			valid_q <= 1'b0;
		end
		else
		begin
			// a redirect kills the word being read this cycle
			valid_q <= i_run & ~i_branch;
			if (!i_run)
				o_pc <= '0; // park at the start while idle
			else if (i_branch)
				o_pc <= i_branch_target;
			else
				o_pc <= o_pc + 1'b1;
		end
	end

	// address of the word now on the memory output
	always_ff @(posedge clk)
	begin
		o_instr_pc <= o_pc;
	end

	assign o_instr = valid_q ? instr_u'(rdata) : INSTR_NOP;

	// program may only be loaded while the core is stopped
	a_load_idle: assert property (@(posedge clk) disable iff (reset) !(i_load_en && i_run))
		else $error("program load while running");

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage import pat_pkg::*; #(
	parameter int PROG_AW = 6
) (
	input  logic clk,
	input  logic reset,
	input  instr_u i_instr,
	input  logic [PROG_AW-1:0] i_instr_pc,
	input  logic i_squash,
	input  logic [DATA_W-1:0] i_in0,
	input  logic [DATA_W-1:0] i_in1,
	input  logic [DATA_W-1:0] i_in2,
	input  logic [DATA_W-1:0] i_rd_a,
	input  logic [DATA_W-1:0] i_rd_b,
	output logic [REG_AW-1:0] o_ra_addr,
	output logic [REG_AW-1:0] o_rb_addr,
	output alu_op_e o_alu_op,
	output logic [DATA_W-1:0] o_a,
	output logic [DATA_W-1:0] o_b,
	output logic [REG_AW-1:0] o_rn,
	output cond_e o_cond,
	output logic o_wr_reg,
	output logic o_is_out,
	output logic o_is_test,
	output logic o_is_branch,
	output logic [PROG_AW-1:0] o_target
);

	alu_op_e alu_op;
	logic wr_reg;
	logic is_out;
	logic is_test;
	logic is_branch;
	logic is_ldi;
	logic is_in;
	logic use_reg_b;
	logic is_long;
	op0_e op0;
	logic [DATA_W-1:0] imm_ext;
	logic [DATA_W-1:0] in_byte;
	logic [DATA_W-1:0] a_next;
	logic [DATA_W-1:0] b_next;

	assign is_long = (i_instr.l.op8 != OP8_PFX);
	assign op0 = op0_e'({i_instr.s.spare, i_instr.s.imm3}); // low nibble read as op0

	// ============================================================
	// opcode decode
	// ============================================================
	always_comb
	begin
		alu_op = ALU_PASS_B;
		wr_reg = 1'b0;
		is_out = 1'b0;
		is_test = 1'b0;
		is_branch = 1'b0;
		is_ldi = 1'b0;
		is_in = 1'b0;
		use_reg_b = 1'b0;
		if (is_long)
		begin
			use_reg_b = i_instr.l.op8[0]; // odd long opcodes take a register
			wr_reg = 1'b1;
			case (i_instr.l.op8)
				OP8_ORI, OP8_ORR: alu_op = ALU_OR;
				OP8_ANDI, OP8_ANDR: alu_op = ALU_AND;
				OP8_ADDI, OP8_ADDR: alu_op = ALU_ADD;
				OP8_SUBI, OP8_SUBR: alu_op = ALU_SUB;
				OP8_LDI:
				begin
					alu_op = ALU_OR; // 0 | imm
					is_ldi = 1'b1;
				end
				OP8_BF:
				begin
					wr_reg = 1'b0;
					is_branch = 1'b1;
				end
				default: wr_reg = 1'b0;
			endcase
		end
		else if (i_instr.s.op3 != OP3_PFX0)
		begin
			use_reg_b = i_instr.s.op3[0];
			wr_reg = 1'b1;
			case (i_instr.s.op3)
				OP3_SHLZI, OP3_SHLZR: alu_op = ALU_SHLZ;
				OP3_SHLOI, OP3_SHLOR: alu_op = ALU_SHLO;
				OP3_SHRZI, OP3_SHRZR: alu_op = ALU_SHRZ;
				OP3_SHROI, OP3_SHROR: alu_op = ALU_SHRO;
				OP3_IN: is_in = 1'b1;
				OP3_OUT:
				begin
					wr_reg = 1'b0;
					is_out = 1'b1;
				end
				default: wr_reg = 1'b0;
			endcase
		end
		else
		begin
			case (op0)
				OP0_NOT:
				begin
					alu_op = ALU_NOT;
					wr_reg = 1'b1;
				end
				OP0_TEST: is_test = 1'b1;
				default: ; // nop
			endcase
		end
	end

	// one-hot input select, anything else reads input 0
	always_comb
	begin
		case (i_instr.s.imm3)
			3'b010: in_byte = i_in1;
			3'b100: in_byte = i_in2;
			default: in_byte = i_in0;
		endcase
	end

	assign imm_ext = is_long ? i_instr.l.imm8 : {{(DATA_W-3){1'b0}}, i_instr.s.imm3};

	assign o_ra_addr = i_instr.l.rn;
	assign o_rb_addr = i_instr.l.imm8[REG_AW-1:0]; // same bits as imm3

	assign a_next = is_ldi ? '0 : (is_in ? in_byte : i_rd_a);
	assign b_next = is_in ? in_byte : (use_reg_b ? i_rd_b : imm_ext);

	// ============================================================
	// decode register
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (reset || i_squash)
		begin
			o_wr_reg <= 1'b0;
			o_is_out <= 1'b0;
			o_is_test <= 1'b0;
			o_is_branch <= 1'b0;
		end
		else
		begin
			o_wr_reg <= wr_reg;
			o_is_out <= is_out;
			o_is_test <= is_test;
			o_is_branch <= is_branch;
		end
	end

	always_ff @(posedge clk)
	begin
		o_alu_op <= alu_op;
		o_a <= a_next;
		o_b <= b_next;
		o_rn <= i_instr.l.rn;
		o_cond <= i_instr.l.cond;
		o_target <= i_instr_pc + PROG_AW'($signed(i_instr.l.imm8)); // relative to the BF
	end

endmodule

// ==== src/data_regs.sv ====
`timescale 1ns/10ps

module data_regs import pat_pkg::*; (
	input  logic clk,
	input  logic [REG_AW-1:0] i_ra_addr,
	input  logic [REG_AW-1:0] i_rb_addr,
	input  logic i_we,
	input  logic [REG_AW-1:0] i_waddr,
	input  logic [DATA_W-1:0] i_wdata,
	output logic [DATA_W-1:0] o_ra,
	output logic [DATA_W-1:0] o_rb
);

	logic [DATA_W-1:0] regs [2**REG_AW];

	always_ff @(posedge clk)
	begin
		if (i_we)
			regs[i_waddr] <= i_wdata;
	end

	assign o_ra = regs[i_ra_addr]; // no bypass, writer and reader need a gap
	assign o_rb = regs[i_rb_addr];

	a_wdata_known: assert property (@(posedge clk) i_we |-> !$isunknown(i_wdata))
		else $error("register write with unknown data");

endmodule

// ==== src/alu.sv ====
`timescale 1ns/10ps

module alu import pat_pkg::*; (
	input  alu_op_e i_op,
	input  logic [DATA_W-1:0] i_a,
	input  logic [DATA_W-1:0] i_b,
	output logic [DATA_W-1:0] o_y
);

	logic [2:0] amt;

	assign amt = {1'b0, i_b[1:0]} + 3'd1; // shift by 1 to 4

	always_comb
	begin
		case (i_op)
			ALU_OR: o_y = i_a | i_b;
			ALU_AND: o_y = i_a & i_b;
			ALU_ADD: o_y = i_a + i_b;   // wraps mod 256
			ALU_SUB: o_y = i_a - i_b;
			ALU_NOT: o_y = ~i_a;
			ALU_SHLZ: o_y = i_a << amt;
			// one fill: shift the complement and invert back
			ALU_SHLO: o_y = ~(~i_a << amt);
			ALU_SHRZ: o_y = i_a >> amt;
			ALU_SHRO: o_y = ~(~i_a >> amt);
			default: o_y = i_b;          // pass b, used by IN
		endcase
	end

endmodule

// ==== src/commit_stage.sv ====
`timescale 1ns/10ps

module commit_stage import pat_pkg::*; #(
	parameter int PROG_AW = 6
) (
	input  logic clk,
	input  logic reset,
	input  cond_e i_cond,
	input  logic [REG_AW-1:0] i_rn,
	input  logic [DATA_W-1:0] i_y,
	input  logic [DATA_W-1:0] i_a,
	input  logic i_wr_reg,
	input  logic i_is_out,
	input  logic i_is_test,
	input  logic i_is_branch,
	input  logic [PROG_AW-1:0] i_target,
	output logic o_we,
	output logic [REG_AW-1:0] o_waddr,
	output logic [DATA_W-1:0] o_wdata,
	output logic o_branch,
	output logic [PROG_AW-1:0] o_branch_target,
	output logic [DATA_W-1:0] o_out,
	output logic o_out_valid
);

	logic z;
	logic n;
	logic cond_ok;

	always_comb
	begin
		case (i_cond)
			COND_Z: cond_ok = z;
			COND_NZ: cond_ok = ~z;
			COND_N: cond_ok = n;
			default: cond_ok = 1'b1;
		endcase
	end

	assign o_we = cond_ok & i_wr_reg;
	assign o_waddr = i_rn;
	assign o_wdata = i_y;
	assign o_branch = cond_ok & i_is_branch; // redirect in the commit cycle
	assign o_branch_target = i_target;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			z <= 1'b0;
			n <= 1'b0;
			o_out <= '0;
			o_out_valid <= 1'b0;
		end
		else
		begin
			o_out_valid <= cond_ok & i_is_out;
			if (cond_ok & i_is_out)
				o_out <= i_a;
			if (cond_ok & i_is_test)
			begin
				z <= (i_a == '0);
				n <= i_a[DATA_W-1];
			end
		end
	end

	// the branch and its two squashed successors never produce output
	a_branch_no_out: assert property (@(posedge clk) disable iff (reset)
		o_branch |=> !o_out_valid [*3])
		else $error("output committed in a branch shadow");

endmodule

// ==== src/pat_core.sv ====
`timescale 1ns/10ps

module pat_core import pat_pkg::*; #(
	parameter int PROG_AW = 6
) (
	input  logic clk,
	input  logic reset,
	input  logic i_load_en,
	input  logic [PROG_AW-1:0] i_load_addr,
	input  logic [INSTR_W-1:0] i_load_data,
	input  logic i_run,
	input  logic [DATA_W-1:0] i_in0,
	input  logic [DATA_W-1:0] i_in1,
	input  logic [DATA_W-1:0] i_in2,
	output logic [PROG_AW-1:0] o_pc,
	output logic [DATA_W-1:0] o_out,
	output logic o_out_valid
);

	instr_u instr;
	logic [PROG_AW-1:0] instr_pc;
	logic branch;
	logic [PROG_AW-1:0] branch_target;
	logic [REG_AW-1:0] ra_addr;
	logic [REG_AW-1:0] rb_addr;
	logic [DATA_W-1:0] rd_a;
	logic [DATA_W-1:0] rd_b;
	alu_op_e alu_op;
	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;
	logic [DATA_W-1:0] alu_y;
	logic [REG_AW-1:0] rn;
	cond_e cond;
	logic wr_reg;
	logic is_out;
	logic is_test;
	logic is_branch;
	logic [PROG_AW-1:0] target;
	logic we;
	logic [REG_AW-1:0] waddr;
	logic [DATA_W-1:0] wdata;

	// ============================================================
	// input side
	// ============================================================
	fetch_unit #(
		.PROG_AW(PROG_AW)
	) fetch_unit_i (
		.clk(clk),
		.reset(reset),
		.i_run(i_run),
		.i_load_en(i_load_en),
		.i_load_addr(i_load_addr),
		.i_load_data(i_load_data),
		.i_branch(branch),
		.i_branch_target(branch_target),
		.o_pc(o_pc),
		.o_instr(instr),
		.o_instr_pc(instr_pc)
	);

	// ============================================================
	// processing
	// ============================================================
	decode_stage #(
		.PROG_AW(PROG_AW)
	) decode_stage_i (
		.clk(clk),
		.reset(reset),
		.i_instr(instr),
		.i_instr_pc(instr_pc),
		.i_squash(branch),
		.i_in0(i_in0),
		.i_in1(i_in1),
		.i_in2(i_in2),
		.i_rd_a(rd_a),
		.i_rd_b(rd_b),
		.o_ra_addr(ra_addr),
		.o_rb_addr(rb_addr),
		.o_alu_op(alu_op),
		.o_a(op_a),
		.o_b(op_b),
		.o_rn(rn),
		.o_cond(cond),
		.o_wr_reg(wr_reg),
		.o_is_out(is_out),
		.o_is_test(is_test),
		.o_is_branch(is_branch),
		.o_target(target)
	);

	data_regs data_regs_i (
		.clk(clk),
		.i_ra_addr(ra_addr),
		.i_rb_addr(rb_addr),
		.i_we(we),
		.i_waddr(waddr),
		.i_wdata(wdata),
		.o_ra(rd_a),
		.o_rb(rd_b)
	);

	alu alu_i (
		.i_op(alu_op),
		.i_a(op_a),
		.i_b(op_b),
		.o_y(alu_y)
	);

	// ============================================================
	// output side
	// ============================================================
	commit_stage #(
		.PROG_AW(PROG_AW)
	) commit_stage_i (
		.clk(clk),
		.reset(reset),
		.i_cond(cond),
		.i_rn(rn),
		.i_y(alu_y),
		.i_a(op_a),
		.i_wr_reg(wr_reg),
		.i_is_out(is_out),
		.i_is_test(is_test),
		.i_is_branch(is_branch),
		.i_target(target),
		.o_we(we),
		.o_waddr(waddr),
		.o_wdata(wdata),
		.o_branch(branch),
		.o_branch_target(branch_target),
		.o_out(o_out),
		.o_out_valid(o_out_valid)
	);

endmodule

// ==== bench/pat_programs.svh ====
`ifndef PAT_PROGRAMS_SVH
`define PAT_PROGRAMS_SVH

// ============================================================
// instruction encoders
// ============================================================
function automatic logic [INSTR_W-1:0] lng(input logic [2:0] rn, input cond_e c,
	input op8_e op, input logic [7:0] imm);
	return {rn, c, op, imm};
endfunction

function automatic logic [INSTR_W-1:0] sht(input logic [2:0] rn, input cond_e c,
	input op3_e op, input logic [2:0] imm);
	return {rn, c, OP8_PFX, op, 1'b0, imm};
endfunction

function automatic logic [INSTR_W-1:0] zop(input logic [2:0] rn, input cond_e c,
	input op0_e op);
	return {rn, c, OP8_PFX, OP3_PFX0, op};
endfunction

function automatic logic [INSTR_W-1:0] nop_word();
	return zop(3'd0, COND_AL, OP0_NOP);
endfunction

function automatic logic [INSTR_W-1:0] out_word(input logic [2:0] rn, input cond_e c);
	return sht(rn, c, OP3_OUT, 3'd0);
endfunction

task automatic put(input logic [INSTR_W-1:0] w);
	prog[plen] = w;
	plen++;
endtask

task automatic want(input logic [7:0] v);
	exp_mem[exp_cnt] = v;
	exp_cnt++;
endtask

// branch to itself, parks the core at the end
task automatic put_halt();
	put(lng(3'd0, COND_AL, OP8_BF, 8'd0));
endtask

// ============================================================
// programs
// ============================================================
task automatic build_arith();
	logic [7:0] acc;
	op8_e ops [8];
	logic [7:0] args [8];
	logic [7:0] b;
	int i;
	ops = '{OP8_ORI, OP8_ANDI, OP8_ADDI, OP8_SUBI, OP8_ORR, OP8_ANDR, OP8_ADDR, OP8_SUBR};
	args = '{8'h81, 8'hf0, 8'h9c, 8'he7, 8'd2, 8'd2, 8'd2, 8'd2};
	acc = 8'h5a;
	put(lng(3'd2, COND_AL, OP8_LDI, 8'h37)); // r2 is the register operand
	put(lng(3'd1, COND_AL, OP8_LDI, acc));
	put(nop_word());
	put(out_word(3'd1, COND_AL));
	want(acc);
	for (i = 0; i < 8; i++)
	begin
		b = (i < 4) ? args[i] : 8'h37;
		case (i % 4)
			0: acc = acc | b;
			1: acc = acc & b;
			2: acc = acc + b;
			default: acc = acc - b;
		endcase
		put(lng(3'd1, COND_AL, ops[i], args[i]));
		put(nop_word());
		put(out_word(3'd1, COND_AL));
		want(acc);
	end
	put_halt();
endtask

task automatic build_shift(input int kind);
	logic [7:0] base;
	int i;
	base = 8'h96;
	put(lng(3'd7, COND_AL, OP8_LDI, 8'd2)); // register amount 2, shifts by 3
	for (i = 0; i < 5; i++)
	begin
		put(lng(3'd2, COND_AL, OP8_LDI, base));
		put(nop_word());
		if (i < 4)
			put(sht(3'd2, COND_AL, op3_e'(4'(2 * kind)), 3'(i)));
		else
			put(sht(3'd2, COND_AL, op3_e'(4'(2 * kind + 1)), 3'd7));
		put(nop_word());
		put(out_word(3'd2, COND_AL));
		want(shift_ref(kind, base, (i < 4) ? i + 1 : 3));
	end
	if (kind == 0)
	begin
		put(lng(3'd3, COND_AL, OP8_LDI, base));
		put(nop_word());
		put(zop(3'd3, COND_AL, OP0_NOT));
		put(nop_word());
		put(out_word(3'd3, COND_AL));
		want(~base);
	end
	put_halt();
endtask

task automatic build_in(input logic [7:0] b0, input logic [7:0] b1, input logic [7:0] b2);
	logic [2:0] sels [5];
	int i;
	sels = '{3'b001, 3'b010, 3'b100, 3'b000, 3'b110};
	for (i = 0; i < 5; i++)
	begin
		put(sht(3'd1, COND_AL, OP3_IN, sels[i]));
		put(nop_word());
		put(out_word(3'd1, COND_AL));
		want(in_ref(sels[i], b0, b1, b2));
	end
	put_halt();
endtask

task automatic build_branch();
	put(lng(3'd1, COND_AL, OP8_LDI, 8'h00));
	put(lng(3'd2, COND_AL, OP8_LDI, 8'h11));
	put(lng(3'd3, COND_AL, OP8_LDI, 8'h22));
	put(lng(3'd4, COND_AL, OP8_LDI, 8'h33));
	put(nop_word());
	put(zop(3'd1, COND_AL, OP0_TEST));  // 5: z set
	put(out_word(3'd2, COND_Z));        // taken
	put(out_word(3'd3, COND_NZ));       // dropped
	put(lng(3'd0, COND_AL, OP8_BF, 8'd3)); // 8: jump to 11
	put(out_word(3'd3, COND_AL));
	put(out_word(3'd3, COND_AL));
	put(out_word(3'd4, COND_AL));
	want(8'h11);
	want(8'h33);
	// counted loop, r5 from 3 down to 1
	put(lng(3'd5, COND_AL, OP8_LDI, 8'd3));
	put(nop_word());
	put(out_word(3'd5, COND_AL));       // 14: loop top
	put(lng(3'd5, COND_AL, OP8_SUBI, 8'd1));
	put(nop_word());
	put(zop(3'd5, COND_AL, OP0_TEST));
	put(lng(3'd0, COND_NZ, OP8_BF, 8'hfc)); // 18: back to 14
	put(nop_word());
	put(nop_word());
	want(8'd3);
	want(8'd2);
	want(8'd1);
	put_halt();
endtask

`endif

// ==== bench/pat_tb.sv ====
`timescale 1ns/10ps

module pat_tb import pat_pkg::*;;

	localparam int PROG_AW = 6;
	localparam int WAIT_LIMIT = 400;

	logic clk;
	logic reset;
	logic i_load_en;
	logic [PROG_AW-1:0] i_load_addr;
	logic [INSTR_W-1:0] i_load_data;
	logic i_run;
	logic [DATA_W-1:0] i_in0;
	logic [DATA_W-1:0] i_in1;
	logic [DATA_W-1:0] i_in2;
	logic [PROG_AW-1:0] o_pc;
	logic [DATA_W-1:0] o_out;
	logic o_out_valid;

	logic [INSTR_W-1:0] prog [2**PROG_AW];
	int plen;
	logic [7:0] exp_mem [256];
	int exp_cnt;
	int seen;
	int seen_base;
	int errors;
	int tests;
	int failed;
	logic idle_chk;
	logic timed_out;
	logic [31:0] lcg_state;

	pat_core #(
		.PROG_AW(PROG_AW)
	) pat_core_i (
		.clk(clk),
		.reset(reset),
		.i_load_en(i_load_en),
		.i_load_addr(i_load_addr),
		.i_load_data(i_load_data),
		.i_run(i_run),
		.i_in0(i_in0),
		.i_in1(i_in1),
		.i_in2(i_in2),
		.o_pc(o_pc),
		.o_out(o_out),
		.o_out_valid(o_out_valid)
	);

	always #50 clk = ~clk;

	// committed output count indexes the expected list
	always @(posedge clk)
	begin
		if (reset)
			seen <= 0;
		else if (o_out_valid)
			seen <= seen + 1;
	end

	// ============================================================
	// reference rules
	// ============================================================
	function automatic logic [7:0] shift_ref(input int kind, input logic [7:0] v, input int amt);
		logic [7:0] r;
		int i;
		r = v;
		for (i = 0; i < amt; i++)
		begin
			case (kind)
				0: r = {r[6:0], 1'b0};
				1: r = {r[6:0], 1'b1};
				2: r = {1'b0, r[7:1]};
				default: r = {1'b1, r[7:1]};
			endcase
		end
		return r;
	endfunction

	function automatic logic [7:0] in_ref(input logic [2:0] sel, input logic [7:0] b0,
		input logic [7:0] b1, input logic [7:0] b2);
		if (sel == 3'b010)
			return b1;
		if (sel == 3'b100)
			return b2;
		return b0; // 001 and anything not one-hot
	endfunction

	function automatic logic [7:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	`include "pat_programs.svh"

	// ============================================================
	// checks
	// ============================================================
	a_out_match: assert property (@(posedge clk) disable iff (reset)
		o_out_valid |-> (seen - seen_base < exp_cnt && o_out == exp_mem[seen - seen_base]))
	else
	begin
		errors++;
		$display("error at %0t: output %h is not the next expected value", $time, o_out);
	end

	a_idle: assert property (@(posedge clk) disable iff (reset)
		idle_chk |-> (o_pc == '0 && !o_out_valid))
	else
	begin
		errors++;
		$display("error at %0t: core active while idle, pc %0d", $time, o_pc);
	end

	// ============================================================
	// test flow
	// ============================================================
	task automatic load_program();
		int a;
		for (a = 0; a < 2**PROG_AW; a++)
		begin
			@(posedge clk);
			i_load_en <= 1'b1;
			i_load_addr <= PROG_AW'(a);
			i_load_data <= (a < plen) ? prog[a] : nop_word();
		end
		@(posedge clk);
		i_load_en <= 1'b0;
	endtask

	task automatic report(input string name, input int err_start);
		tests++;
		if (timed_out)
		begin
			failed++;
			$display("test %s: timed out", name);
		end
		else if (errors == err_start)
			$display("test %s: ok", name);
		else
		begin
			failed++;
			$display("test %s: %0d errors", name, errors - err_start);
		end
	endtask

	task automatic run_test(input string name);
		int err_start;
		int cycles;
		if (timed_out)
			return;
		err_start = errors;
		seen_base = seen;
		load_program();
		@(posedge clk);
		i_run <= 1'b1;
		cycles = 0;
		while (seen - seen_base < exp_cnt && !timed_out)
		begin
			@(posedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT)
			begin
				timed_out = 1'b1;
				$display("timeout: test %s saw %0d of %0d outputs", name,
					seen - seen_base, exp_cnt);
			end
		end
		repeat (12) @(posedge clk); // room for stray outputs
		i_run <= 1'b0;
		repeat (4) @(posedge clk);
		report(name, err_start);
	endtask

	task automatic start_program();
		plen = 0;
		exp_cnt = 0;
	endtask

	initial
	begin
		logic [7:0] b0;
		logic [7:0] b1;
		logic [7:0] b2;
		int k;
		int err_start;
		clk = 1'b0;
		reset = 1'b1;
		i_load_en = 1'b0;
		i_load_addr = '0;
		i_load_data = '0;
		i_run = 1'b0;
		i_in0 = '0;
		i_in1 = '0;
		i_in2 = '0;
		idle_chk = 1'b0;
		timed_out = 1'b0;
		errors = 0;
		tests = 0;
		failed = 0;
		seen_base = 0;
		exp_cnt = 0;
		plen = 0;
		lcg_state = 32'h8bd7_1bc2;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		err_start = errors;
		@(posedge clk);
		idle_chk <= 1'b1;
		repeat (20) @(posedge clk);
		idle_chk <= 1'b0;
		report("idle", err_start);

		start_program();
		build_arith();
		run_test("arith");

		for (k = 0; k < 4; k++)
		begin
			start_program();
			build_shift(k);
			run_test($sformatf("shift%0d", k));
		end

		b0 = next_rand();
		b1 = next_rand();
		b2 = next_rand();
		@(posedge clk);
		i_in0 <= b0;
		i_in1 <= b1;
		i_in2 <= b2;
		start_program();
		build_in(b0, b1, b2);
		run_test("in");

		start_program();
		build_branch();
		run_test("branch");

		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (!timed_out && errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+bench
src/pat_pkg.sv
src/prog_mem.sv
src/fetch_unit.sv
src/decode_stage.sv
src/data_regs.sv
src/alu.sv
src/commit_stage.sv
src/pat_core.sv
bench/pat_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pat testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module pat_tb -f files.f -o pat_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/pat_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1
